/* src/nocArbPkg.sv */
package nocArbPkg;

  localparam int NumPorts    = 5;
  localparam int LengthWidth = 12;

  // rotation order of the router ports
  typedef enum logic [2:0]
  {
    L,
    N,
    E,
    W,
    S
  } portIdx_e;

  // flit identifier in the top three bits of every word
  typedef enum logic [2:0]
  {
    HEAD = 3'd1,
    BODY = 3'd2,
    TAIL = 3'd3
  } flitKind_e;

  // one 32-bit flit word, read as head or as body/tail
  typedef union packed
  {
    struct packed
    {
      flitKind_e              kind;
      logic [LengthWidth-1:0] length;   // packet length in flits
      logic [16:0]            dest;
    } head;
    struct packed
    {
      flitKind_e   kind;
      logic [28:0] payload;
    } body;
  } flitWord_u;

  // one word per port, L in slice 0
  typedef flitWord_u [NumPorts-1:0] flitArray_t;

  // bit 0 idle, bits 1 to 5 are L to S
  typedef logic [NumPorts:0] grant_t;

endpackage

/* src/portReqIf.sv */
`timescale 1ns/100ps

interface portReqIf import nocArbPkg::*;
();

  logic [NumPorts-1:0]                  req;      // staged request levels
  flitKind_e [NumPorts-1:0]             kind;
  logic [NumPorts-1:0][LengthWidth-1:0] length;   // head view length per port
  flitArray_t                           flit;

  // input stage drives everything
  modport stage
  (
    output req,
    output kind,
    output length,
    output flit
  );

  modport arb
  (
    input req,
    input kind,
    input length
  );

  modport mux
  (
    input req,
    input flit
  );

endinterface

/* src/inputStage.sv */
`timescale 1ns/100ps

module inputStage import nocArbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] inReq,
  input  flitArray_t          inFlit,
  portReqIf.stage             stageIf
);

  logic [NumPorts-1:0] reqQ;
  flitArray_t          flitQ;

  //////////////////////////////////////////////////
  // input registers

  always_ff @(posedge clk)
  begin
    if (rst)
      reqQ <= '0;
    else
      reqQ <= inReq;
  end

  // payload path
  always_ff @(posedge clk)
  begin
    flitQ <= inFlit;
  end

  //////////////////////////////////////////////////
  // flit decode

  // kind sits in the same place in both views, so the head view serves both
  always_comb
  begin
    for (int p = 0; p < NumPorts; p++)
    begin
      stageIf.kind[p]   = flitQ[p].head.kind;
      stageIf.length[p] = flitQ[p].head.length;   // only meaningful on HEAD
    end
  end

  assign stageIf.req  = reqQ;
  assign stageIf.flit = flitQ;

endmodule

/* src/packetTimer.sv */
`timescale 1ns/100ps

module packetTimer import nocArbPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  flitKind_e              kind,
  input  logic [LengthWidth-1:0] length,
  input  logic                   run,
  output logic                   timesUp
);

  logic [LengthWidth-1:0] limit;   // budget from the last head flit
  logic [LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (kind == HEAD)
        limit <= length;   // body and tail leave it alone
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // a limit lowered mid-packet still ends the hold
  assign timesUp = (count >= limit);

  // the arbiter only runs a timer that has budget left
  assert property (@(posedge clk) disable iff (rst) run |-> (count <= limit))
    else $error("packetTimer: count %0d beyond limit %0d", count, limit);

endmodule

/* src/outputArbiter.sv */
`timescale 1ns/100ps

module outputArbiter import nocArbPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  portReqIf.arb  arbIf,
  output grant_t state
);

  localparam grant_t Idle = grant_t'(1);

  logic [NumPorts-1:0] run;
  logic [NumPorts-1:0] timesUp;
  grant_t              nextState;
  logic                hold;
  logic                found;
  int                  base;   // first port looked at when rotating
  int                  cand;

  //////////////////////////////////////////////////
  // per-port packet timers

  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    packetTimer timer0
    (
      .clk     (clk),
      .rst     (rst),
      .kind    (arbIf.kind[p]),
      .length  (arbIf.length[p]),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  //////////////////////////////////////////////////
  // one-hot state

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Idle;
    else
      state <= nextState;
  end

  always_comb
  begin
    run       = '0;
    hold      = 1'b0;
    found     = 1'b0;
    base      = 0;   // idle searches from L
    cand      = 0;
    nextState = Idle;

    // current owner keeps the port while it requests with budget left
    for (int p = 0; p < NumPorts; p++)
    begin
      if (state[p+1])
      begin
        base = (p + 1) % NumPorts;   // S wraps back to L
        if (arbIf.req[p] && !timesUp[p])
        begin
          hold   = 1'b1;
          run[p] = 1'b1;
        end
      end
    end

    if (hold)
    begin
      nextState = state;
    end
    else
    begin
      // rotate; the old owner comes last and may win again
      for (int k = 0; k < NumPorts; k++)
      begin
        cand = base + k;
        if (cand >= NumPorts)
          cand = cand - NumPorts;
        if (!found && arbIf.req[cand])
        begin
          found     = 1'b1;
          nextState = grant_t'(1) << (cand + 1);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // checks

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("outputArbiter: state %b not one-hot", state);

  // a running timer belongs to a requesting owner that keeps the grant
  assert property (@(posedge clk) disable iff (rst)
    (|run) |-> ((run & ~arbIf.req) == '0) ##1 $stable(state))
    else $error("outputArbiter: timer ran without a held request");

endmodule

/* src/switchMux.sv */
`timescale 1ns/100ps

module switchMux import nocArbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  portReqIf.mux     muxIf,
  input  grant_t    state,
  output flitWord_u outFlit,
  output logic      outValid
);

  portIdx_e selPort;
  logic     selValid;   // some port owns the output

  // one-hot state to port index
  always_comb
  begin
    selPort  = L;
    selValid = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (state[p+1])
      begin
        selPort  = portIdx_e'(p);
        selValid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid && muxIf.req[selPort];
  end

  always_ff @(posedge clk)
  begin
    outFlit <= muxIf.flit[selPort];   // whole word, both views pass
  end

  // an idle arbiter never produces a valid flit
  assert property (@(posedge clk) disable iff (rst) state[0] |=> !outValid)
    else $error("switchMux: outValid after idle state");

endmodule

/* src/routerOutputPort.sv */
`timescale 1ns/100ps

module routerOutputPort import nocArbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] inReq,
  input  flitArray_t          inFlit,
  output flitWord_u           outFlit,
  output logic                outValid,
  output logic [NumPorts-1:0] grant
);

  grant_t state;   // arbiter state, bit 0 idle

  portReqIf reqIf ();

  //////////////////////////////////////////////////
  // stage, arbiter, switch

  inputStage stage0
  (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inFlit  (inFlit),
    .stageIf (reqIf.stage)
  );

  outputArbiter arb0
  (
    .clk   (clk),
    .rst   (rst),
    .arbIf (reqIf.arb),
    .state (state)
  );

  switchMux mux0
  (
    .clk      (clk),
    .rst      (rst),
    .muxIf    (reqIf.mux),
    .state    (state),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  assign grant = state[NumPorts:1];   // drop the idle bit

endmodule

/* tb/tbRouterOutputPort.sv */
`timescale 1ns/100ps

module tbRouterOutputPort import nocArbPkg::*;
();

  localparam int ResetCycles    = 4;
  localparam int DirectedCycles = 20 + 18 + 9 + 16;
  localparam int RandomCycles   = 600;
  localparam int DrainCycles    = 6;
  localparam int CycleLimit     = ResetCycles + DirectedCycles + RandomCycles + DrainCycles + 50;

  // expected registers of the output port, updated once per rising edge
  typedef struct packed
  {
    logic [NumPorts-1:0]                  reqQ;
    flitArray_t                           flitQ;
    logic [NumPorts-1:0][LengthWidth-1:0] limit;   // latched head lengths
    logic                                 busy;    // some port owns the output
    logic [2:0]                           owner;
    logic [LengthWidth-1:0]               held;    // cycles the owner has held
    logic                                 outValid;
    flitWord_u                            outFlit;
  } model_t;

  logic                clk;
  logic                rst;
  logic [NumPorts-1:0] inReq;
  flitArray_t          inFlit;
  flitWord_u           outFlit;
  logic                outValid;
  logic [NumPorts-1:0] grant;

  model_t      model;
  logic [31:0] lfsr;
  int          grantErrs;
  int          validErrs;
  int          flitErrs;
  int          cycleCount;

  routerOutputPort dut0
  (
    .clk      (clk),
    .rst      (rst),
    .inReq    (inReq),
    .inFlit   (inFlit),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grant    (grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random bits and flit builders

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic flitWord_u headFlit(input logic [LengthWidth-1:0] len,
                                         input logic [16:0] dest);
    flitWord_u w;
    w.head.kind   = HEAD;
    w.head.length = len;
    w.head.dest   = dest;
    return w;
  endfunction

  function automatic flitWord_u bodyFlit(input flitKind_e kind, input logic [28:0] payload);
    flitWord_u w;
    w.body.kind    = kind;
    w.body.payload = payload;
    return w;
  endfunction

  // mostly body and tail, now and then a head or an unused code
  function automatic flitWord_u randomFlit();
    flitWord_u  w;
    logic [2:0] pick;
    logic [1:0] code;
    pick = 3'(randBits(3));
    if (pick == 3'd0)
      w = headFlit(LengthWidth'(randBits(3)), 17'(randBits(17)));
    else if (pick == 3'd6)
    begin
      code = 2'(randBits(2));
      w    = bodyFlit(flitKind_e'({1'b1, code}), 29'(randBits(29)));   // codes 4 to 7
    end
    else
      w = bodyFlit(pick[2] ? TAIL : BODY, 29'(randBits(29)));
    return w;
  endfunction

  //////////////////////////////////////////////////
  // reference model

  function automatic model_t refStep(input model_t cur, input logic reset,
                                     input logic [NumPorts-1:0] req, input flitArray_t flit);
    model_t nxt;
    logic   keep;
    int     start;
    int     idx;
    nxt       = cur;
    nxt.flitQ = flit;
    if (reset)
    begin
      nxt.reqQ     = '0;
      nxt.limit    = '0;
      nxt.busy     = 1'b0;
      nxt.owner    = 3'd0;
      nxt.held     = '0;
      nxt.outValid = 1'b0;
      return nxt;
    end
    for (int p = 0; p < NumPorts; p++)
      if (cur.flitQ[p].head.kind == HEAD)
        nxt.limit[p] = cur.flitQ[p].head.length;
    nxt.outValid = cur.busy && cur.reqQ[cur.owner];
    nxt.outFlit  = cur.flitQ[cur.owner];
    // owner stays for length+1 cycles while it requests
    keep = cur.busy && cur.reqQ[cur.owner] && (cur.held < cur.limit[cur.owner]);
    if (keep)
      nxt.held = cur.held + 1'b1;
    else
    begin
      nxt.held = '0;
      nxt.busy = 1'b0;
      start    = cur.busy ? (cur.owner + 1) % NumPorts : 0;
      for (int k = NumPorts - 1; k >= 0; k--)   // last hit is first in rotation
      begin
        idx = (start + k) % NumPorts;
        if (cur.reqQ[idx])
        begin
          nxt.busy  = 1'b1;
          nxt.owner = 3'(idx);
        end
      end
    end
    nxt.reqQ = req;
    return nxt;
  endfunction

  function automatic logic [NumPorts-1:0] expGrant(input model_t m);
    return m.busy ? (NumPorts'(1) << m.owner) : '0;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks

  task automatic checkGrant(input logic [NumPorts-1:0] exp, input logic [NumPorts-1:0] act);
    if (act !== exp)
    begin
      grantErrs++;
      $display("FAILED grant at %0t: expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic checkValid(input logic exp, input logic act);
    if (act !== exp)
    begin
      validErrs++;
      $display("FAILED outValid at %0t: expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic checkFlit(input flitWord_u exp, input flitWord_u act);
    if (act !== exp)
    begin
      flitErrs++;
      $display("FAILED outFlit at %0t: expected %h, got %h", $time, exp, act);
    end
  endtask

  // outputs read before this edge's updates land
  always @(posedge clk)
  begin
    if (!rst)
    begin
      checkGrant(expGrant(model), grant);
      checkValid(model.outValid, outValid);
      if (model.outValid)
        checkFlit(model.outFlit, outFlit);
    end
    model = refStep(model, rst, inReq, inFlit);
  end

  //////////////////////////////////////////////////
  // stimulus

  task automatic driveCycle(input logic [NumPorts-1:0] req, input flitArray_t flits);
    @(negedge clk);
    inReq  = req;
    inFlit = flits;
  endtask

  // body and tail flits with random payload on every port
  task automatic holdCycles(input logic [NumPorts-1:0] req, input int n);
    flitArray_t flits;
    for (int c = 0; c < n; c++)
    begin
      for (int p = 0; p < NumPorts; p++)
        flits[p] = bodyFlit(randBits(1) ? TAIL : BODY, 29'(randBits(29)));
      driveCycle(req, flits);
    end
  endtask

  task automatic sendHeads(input logic [NumPorts-1:0] req,
                           input logic [NumPorts-1:0][LengthWidth-1:0] lens);
    flitArray_t flits;
    for (int p = 0; p < NumPorts; p++)
      flits[p] = headFlit(lens[p], 17'(randBits(17)));
    driveCycle(req, flits);
  endtask

  task automatic randomCycles(input int n);
    flitArray_t          flits;
    logic [NumPorts-1:0] req;
    logic [1:0]          r;
    for (int c = 0; c < n; c++)
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        r        = 2'(randBits(2));
        req[p]   = |r;   // about three in four cycles
        flits[p] = randomFlit();
      end
      driveCycle(req, flits);
    end
  endtask

  initial
  begin
    cycleCount = 0;
    while (cycleCount < CycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the run did not end within %0d cycles", CycleLimit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    lfsr      = 32'h22da;
    model     = '0;
    grantErrs = 0;
    validErrs = 0;
    flitErrs  = 0;
    rst       = 1'b1;
    inReq     = '0;
    for (int p = 0; p < NumPorts; p++)
      inFlit[p] = bodyFlit(BODY, '0);
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // idle, then N, W and S contend from idle
    holdCycles('0, 3);
    sendHeads(5'b11010, {12'd2, 12'd2, 12'd2, 12'd2, 12'd2});
    holdCycles(5'b11010, 12);
    holdCycles('0, 4);
    // L with length 1 against E with length 3
    sendHeads(5'b00101, {12'd0, 12'd0, 12'd3, 12'd0, 12'd1});
    holdCycles(5'b00101, 14);
    holdCycles('0, 3);
    // W drops its request early
    sendHeads(5'b01000, {12'd0, 12'd6, 12'd0, 12'd0, 12'd0});
    holdCycles(5'b01000, 3);
    holdCycles('0, 5);
    // body payload bits must not touch the latched lengths
    sendHeads(5'b10010, {12'd2, 12'd0, 12'd0, 12'd4, 12'd0});
    holdCycles(5'b10010, 12);
    holdCycles('0, 3);

    randomCycles(RandomCycles);
    holdCycles('0, DrainCycles);

    $display("errors: grant %0d, outValid %0d, outFlit %0d", grantErrs, validErrs, flitErrs);
    if (grantErrs + validErrs + flitErrs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* nocArb.f */
src/nocArbPkg.sv
src/portReqIf.sv
src/inputStage.sv
src/packetTimer.sv
src/outputArbiter.sv
src/switchMux.sv
src/routerOutputPort.sv
tb/tbRouterOutputPort.sv
